/* verilog/ctrlPkg.sv */
package ctrlPkg;

    typedef enum logic [2:0] {
        aluIdle,
        aluClr,
        aluPass,
        aluAdd,
        aluSub,
        aluMul,
        aluInc
    } aluOp_t;

    // source that drives the shared data bus
    typedef enum logic [3:0] {
        busIdle,
        busDMem,
        busIr,
        busAc,
        busR,
        busRc,
        busR1,
        busRp,
        busRq,
        busRl
    } busSel_t;

    typedef struct packed {
        logic pc;
        logic rc;
        logic rp;
        logic rq;
    } regInc_t;

    typedef struct packed {
        logic ar;
        logic r;
        logic pc;
        logic ir;
        logic rl;
        logic rc;
        logic rp;
        logic rq;
        logic r1;
        logic ac;
    } regWrEn_t;

    typedef struct packed {
        aluOp_t   aluOp;
        regInc_t  incReg;
        regWrEn_t wrEnReg;
        busSel_t  busSel;
        logic     dataMemWrEn;
        logic     zWrEn;
    } ctrlWord_t;

    localparam ctrlWord_t ctrlIdle = '0;  // every enum starts at its idle value

    typedef enum logic [3:0] {
        stIdle,
        stFetch,
        stDecode,
        stExec,
        stOperand,   // second memory word into ir
        stAddrAc,
        stAddrIr,
        stLoad,
        stStore,
        stJump,
        stSkip,
        stHalt
    } step_t;

endpackage

/* verilog/isaPkg.sv */
package isaPkg;

    import ctrlPkg::*;

    // moves carry the register number in the upper nibble
    typedef enum logic [7:0] {
        opNop    = 8'd0,
        opEnd    = 8'd1,
        opClac   = 8'd2,
        opLdiac  = 8'd3,
        opLdac   = 8'd4,
        opStr    = 8'd5,
        opStir   = 8'd6,
        opJump   = 8'd7,
        opJmpNz  = 8'd8,
        opJmpZ   = 8'd9,
        opMul    = 8'd10,
        opAdd    = 8'd11,
        opSub    = 8'd12,
        opIncac  = 8'd13,
        opMvRlAc = {4'd1, 4'd15},
        opMvRpAc = {4'd2, 4'd15},
        opMvRqAc = {4'd3, 4'd15},
        opMvRcAc = {4'd4, 4'd15},
        opMvRAc  = {4'd5, 4'd15},
        opMvR1Ac = {4'd6, 4'd15},
        opMvAcRp = {4'd7, 4'd15},
        opMvAcRq = {4'd8, 4'd15},
        opMvAcRl = {4'd9, 4'd15}
    } opcode_t;

    typedef enum logic [3:0] {
        clsExec,      // one execute cycle, word comes from the decoder
        clsEnd,
        clsLoad,
        clsStore,
        clsLoadInd,
        clsStoreInd,
        clsJump,
        clsJmpNz,
        clsJmpZ,
        clsIllegal
    } opClass_t;

    typedef struct packed {
        opClass_t  opClass;
        ctrlWord_t execWord;
    } opInfo_t;

endpackage

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder #(
    parameter int irWidth = 8
) (
    input  logic [irWidth-1:0] ins,
    output isaPkg::opInfo_t    opInfo
);

    import isaPkg::*;
    import ctrlPkg::*;

    opcode_t   op;
    opClass_t  cls;
    ctrlWord_t word;

    assign op = opcode_t'(ins);

    always_comb begin
        cls  = clsExec;
        word = ctrlIdle;
        case (op)
            opNop: begin
                cls = clsExec;  // nothing to do
            end
            opEnd:   cls = clsEnd;
            opLdac:  cls = clsLoad;
            opStr:   cls = clsStore;
            opLdiac: cls = clsLoadInd;
            opStir:  cls = clsStoreInd;
            opJump:  cls = clsJump;
            opJmpNz: cls = clsJmpNz;
            opJmpZ:  cls = clsJmpZ;
            opClac: begin
                word.aluOp      = aluClr;
                word.wrEnReg.ac = 1'b1;
            end
            opAdd, opSub, opIncac: begin
                word.wrEnReg.ac = 1'b1;
                word.aluOp      = (op == opAdd) ? aluAdd : (op == opSub) ? aluSub : aluInc;
                word.busSel     = (op == opAdd) ? busR : (op == opSub) ? busRc : busIdle;
            end
            opMul: begin
                word.aluOp      = aluMul;
                word.wrEnReg.ac = 1'b1;
                word.busSel     = busR1;
                word.incReg     = '{pc: 1'b0, rc: 1'b1, rp: 1'b1, rq: 1'b1};  // step matrix indices
            end
            opMvRlAc, opMvRpAc, opMvRqAc, opMvRcAc, opMvRAc, opMvR1Ac: begin
                word.busSel     = busAc;
                word.wrEnReg.rl = (op == opMvRlAc);
                word.wrEnReg.rp = (op == opMvRpAc);
                word.wrEnReg.rq = (op == opMvRqAc);
                word.wrEnReg.rc = (op == opMvRcAc);
                word.wrEnReg.r  = (op == opMvRAc);
                word.wrEnReg.r1 = (op == opMvR1Ac);
            end
            opMvAcRp, opMvAcRq, opMvAcRl: begin
                word.aluOp      = aluPass;
                word.wrEnReg.ac = 1'b1;
                word.busSel     = (op == opMvAcRp) ? busRp : (op == opMvAcRq) ? busRq : busRl;
            end
            default: cls = clsIllegal;
        endcase
        word.zWrEn = word.wrEnReg.ac;  // z follows every AC update
    end

    assign opInfo.opClass  = cls;
    assign opInfo.execWord = word;

endmodule

/* verilog/stepSequencer.sv */
`timescale 1ns/1ps

module stepSequencer #(
    parameter int memWait = 1
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             start,
    input  logic             zOut,
    input  isaPkg::opInfo_t  opInfo,
    output ctrlPkg::step_t   step,
    output isaPkg::opInfo_t  curOp,
    output logic             done,
    output logic             ready
);

    import isaPkg::*;
    import ctrlPkg::*;

    localparam int cntWidth = (memWait > 0) ? $clog2(memWait + 1) : 1;

    logic [cntWidth-1:0] waitCnt;
    logic                memStep;
    logic                stepDone;
    logic                toLoad;
    step_t               nextStep;

    // memory steps last memWait extra cycles
    assign memStep  = step inside {stFetch, stOperand, stLoad, stStore};
    assign stepDone = !memStep || (waitCnt == cntWidth'(memWait));
    assign toLoad   = curOp.opClass inside {clsLoad, clsLoadInd};

    always_comb begin
        nextStep = step;
        case (step)
            stIdle: begin
                if (start) begin
                    nextStep = stFetch;
                end
            end
            stFetch: begin
                if (stepDone) begin
                    nextStep = stDecode;
                end
            end
            stDecode: begin
                case (opInfo.opClass)
                    clsExec:                 nextStep = stExec;
                    clsEnd:                  nextStep = stHalt;
                    clsLoad, clsStore:       nextStep = stAddrAc;
                    clsLoadInd, clsStoreInd: nextStep = stOperand;
                    clsJump:                 nextStep = stOperand;
                    clsJmpNz:                nextStep = !zOut ? stOperand : stSkip;
                    clsJmpZ:                 nextStep = zOut ? stOperand : stSkip;
                    default:                 nextStep = stIdle;  // illegal opcode
                endcase
            end
            stOperand: begin
                if (stepDone) begin
                    nextStep = (curOp.opClass inside {clsLoadInd, clsStoreInd}) ? stAddrIr : stJump;
                end
            end
            stAddrAc, stAddrIr: begin
                nextStep = toLoad ? stLoad : stStore;
            end
            stLoad, stStore: begin
                if (stepDone) begin
                    nextStep = stFetch;
                end
            end
            stExec, stJump, stSkip: nextStep = stFetch;
            stHalt:                 nextStep = stHalt;
            default:                nextStep = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            step    <= stIdle;
            waitCnt <= '0;
        end else begin
            step <= nextStep;
            if (stepDone) begin
                waitCnt <= '0;
            end else begin
                waitCnt <= waitCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step == stDecode) begin
            curOp <= opInfo;  // held for the rest of the instruction
        end
    end

    assign done  = (step == stHalt);
    assign ready = (step == stIdle);

endmodule

/* verilog/ctrlWordGen.sv */
`timescale 1ns/1ps

module ctrlWordGen (
    input  ctrlPkg::step_t     step,
    input  isaPkg::opInfo_t    curOp,
    output ctrlPkg::ctrlWord_t ctrl
);

    import ctrlPkg::*;

    always_comb begin
        ctrl = ctrlIdle;
        case (step)
            stFetch: begin
                ctrl.wrEnReg.ir = 1'b1;
                ctrl.busSel     = busIdle;
            end
            stDecode: begin
                ctrl.incReg.pc = 1'b1;
                ctrl.busSel    = busDMem;
            end
            stExec: begin
                ctrl = curOp.execWord;
            end
            stOperand: begin
                ctrl.wrEnReg.ir = 1'b1;  // address word from memory
                ctrl.busSel     = busDMem;
            end
            stAddrAc: begin
                ctrl.wrEnReg.ar = 1'b1;
                ctrl.busSel     = busAc;
            end
            stAddrIr: begin
                ctrl.wrEnReg.ar = 1'b1;
                ctrl.incReg.pc  = 1'b1;  // skip past the operand word
                ctrl.busSel     = busIr;
            end
            stLoad: begin
                ctrl.aluOp      = aluPass;
                ctrl.wrEnReg.ac = 1'b1;
                ctrl.zWrEn      = 1'b1;
                ctrl.busSel     = busDMem;
            end
            stStore: begin
                ctrl.dataMemWrEn = 1'b1;
            end
            stJump: begin
                ctrl.wrEnReg.pc = 1'b1;
                ctrl.busSel     = busIr;
            end
            stSkip: begin
                ctrl.incReg.pc = 1'b1;  // untaken branch steps over its target
            end
            stHalt: begin
                ctrl.busSel = busDMem;
            end
            default: begin
                ctrl = ctrlIdle;
            end
        endcase
    end

endmodule

/* verilog/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit #(
    parameter int irWidth = 8,
    parameter int memWait = 1
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  logic               zOut,
    input  logic [irWidth-1:0] ins,
    output ctrlPkg::ctrlWord_t ctrl,
    output logic               done,
    output logic               ready
);

    import isaPkg::*;
    import ctrlPkg::*;

    opInfo_t opInfo;
    opInfo_t curOp;
    step_t   step;

    instrDecoder #(
        .irWidth(irWidth)
    ) i_instrDecoder (
        .ins   (ins),
        .opInfo(opInfo)
    );

    stepSequencer #(
        .memWait(memWait)
    ) i_stepSequencer (
        .clk   (clk),
        .rstN  (rstN),
        .start (start),
        .zOut  (zOut),
        .opInfo(opInfo),
        .step  (step),
        .curOp (curOp),
        .done  (done),
        .ready (ready)
    );

    ctrlWordGen i_ctrlWordGen (
        .step (step),
        .curOp(curOp),
        .ctrl (ctrl)
    );

endmodule

/* tests/controlUnit_props.sv */
`timescale 1ns/1ps

module controlUnitProps (
    input logic               clk,
    input logic               rstN,
    input ctrlPkg::ctrlWord_t ctrl,
    input logic               done,
    input logic               ready
);

    import ctrlPkg::*;

    // halt never shows ready and is never left
    aHaltHeld: assert property (@(posedge clk) disable iff (!rstN) done |-> !ready ##1 done)
        else $error("halt shown with ready or left after done");

    aStoreNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.dataMemWrEn |-> (ctrl.wrEnReg == '0))
        else $error("memory write with a register write enabled");

    aZFollowsAc: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.zWrEn |-> ctrl.wrEnReg.ac)
        else $error("z flag written without an AC write");

endmodule

bind controlUnit controlUnitProps i_props (
    .clk  (clk),
    .rstN (rstN),
    .ctrl (ctrl),
    .done (done),
    .ready(ready)
);

/* tests/tbControlUnit.sv */
`timescale 1ns/1ps

module tbControlUnit;

    import ctrlPkg::*;
    import isaPkg::*;

    localparam int irWidth  = 8;
    localparam int memWait  = 1;
    localparam int numLines = 24;
    localparam logic [7:0] illegalOp = 8'hEE;

    // expected step words, built field by field from the step table
    localparam ctrlWord_t fetchWord = '{aluOp: aluIdle, incReg: 4'b0000,
        wrEnReg: 10'b0001000000, busSel: busIdle, dataMemWrEn: 1'b0, zWrEn: 1'b0};
    localparam ctrlWord_t operandWord = '{aluOp: aluIdle, incReg: 4'b0000,
        wrEnReg: 10'b0001000000, busSel: busDMem, dataMemWrEn: 1'b0, zWrEn: 1'b0};
    localparam ctrlWord_t addrIrWord = '{aluOp: aluIdle, incReg: 4'b1000,
        wrEnReg: 10'b1000000000, busSel: busIr, dataMemWrEn: 1'b0, zWrEn: 1'b0};
    localparam ctrlWord_t loadWord = '{aluOp: aluPass, incReg: 4'b0000,
        wrEnReg: 10'b0000000001, busSel: busDMem, dataMemWrEn: 1'b0, zWrEn: 1'b1};
    localparam ctrlWord_t storeWord = '{aluOp: aluIdle, incReg: 4'b0000,
        wrEnReg: 10'b0000000000, busSel: busIdle, dataMemWrEn: 1'b1, zWrEn: 1'b0};
    localparam ctrlWord_t jumpWord = '{aluOp: aluIdle, incReg: 4'b0000,
        wrEnReg: 10'b0010000000, busSel: busIr, dataMemWrEn: 1'b0, zWrEn: 1'b0};
    localparam ctrlWord_t skipWord = '{aluOp: aluIdle, incReg: 4'b1000,
        wrEnReg: 10'b0000000000, busSel: busIdle, dataMemWrEn: 1'b0, zWrEn: 1'b0};
    localparam ctrlWord_t haltWord = '{aluOp: aluIdle, incReg: 4'b0000,
        wrEnReg: 10'b0000000000, busSel: busDMem, dataMemWrEn: 1'b0, zWrEn: 1'b0};

    logic               clk;
    logic               rstN;
    logic               start;
    logic               zOut;
    logic [irWidth-1:0] ins;
    ctrlWord_t          ctrl;
    logic               done;
    logic               ready;

    logic [23:0] stimMem [0:4*numLines-1];
    ctrlWord_t   trace [$];  // words seen after a decode, up to the next one
    int          errCount;
    int          timeoutCount;
    int          checkCount;

    controlUnit #(
        .irWidth(irWidth),
        .memWait(memWait)
    ) i_dut (
        .clk  (clk),
        .rstN (rstN),
        .start(start),
        .zOut (zOut),
        .ins  (ins),
        .ctrl (ctrl),
        .done (done),
        .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            $display("FAIL %s expected %0h actual %0h", name, expVal, actVal);
            errCount++;
        end
    endtask

    function automatic int countWord(input ctrlWord_t w);
        int n;
        n = 0;
        foreach (trace[i]) begin
            if (trace[i] == w) begin
                n++;
            end
        end
        return n;
    endfunction

    // collects control words until pc increment with the dMem bus shows up
    task automatic runToDecode(input int limit, output bit ok);
        ctrlWord_t w;
        trace.delete();
        ok = 1'b0;
        for (int i = 0; i < limit && !ok; i++) begin
            @(negedge clk);
            w = ctrl;
            if (w.incReg.pc && w.busSel == busDMem) begin
                ok = 1'b1;
            end else begin
                trace.push_back(w);
            end
        end
        if (!ok) begin
            $display("ERROR: no decode cycle within %0d cycles", limit);
            timeoutCount++;
        end
    endtask

    task automatic startRun(input string name, output bit ok);
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        runToDecode(16, ok);
        if (ok) begin
            checkVal({name, " ir write cycles"}, memWait + 1, countWord(fetchWord));
            checkVal({name, " cycles before decode"}, memWait + 1, trace.size());
        end
    endtask

    task automatic checkLine(input string name, input int k);
        logic [7:0] op;
        bit         taken;
        op    = stimMem[4*k][7:0];
        taken = (stimMem[4*k+3] == operandWord);
        checkVal({name, " spacing"}, stimMem[4*k+2], trace.size() + 1);
        checkVal({name, " first word"}, stimMem[4*k+3], trace.size() > 0 ? trace[0] : 'x);
        checkVal({name, " fetch cycles"}, memWait + 1, countWord(fetchWord));
        case (op)
            opLdac:  checkVal({name, " load cycles"}, memWait + 1, countWord(loadWord));
            opStr:   checkVal({name, " store cycles"}, memWait + 1, countWord(storeWord));
            opLdiac, opStir: begin
                checkVal({name, " operand cycles"}, memWait + 1, countWord(operandWord));
                checkVal({name, " address from ir"}, 1, countWord(addrIrWord));
                if (op == opLdiac) begin
                    checkVal({name, " load cycles"}, memWait + 1, countWord(loadWord));
                end else begin
                    checkVal({name, " store cycles"}, memWait + 1, countWord(storeWord));
                end
            end
            opJump, opJmpNz, opJmpZ: begin
                if (taken) begin
                    checkVal({name, " operand cycles"}, memWait + 1, countWord(operandWord));
                    checkVal({name, " pc write"}, 1, countWord(jumpWord));
                end else begin
                    checkVal({name, " pc skip"}, 1, countWord(skipWord));
                end
            end
            default: ;
        endcase
    endtask

    task automatic runTests();
        bit    ok;
        bit    seen;
        string name;
        repeat (3) begin
            @(negedge clk);
            checkVal("reset ready", 1, ready);
            checkVal("reset done", 0, done);
            checkVal("reset ctrl", 0, ctrl);
        end
        @(posedge clk);
        #2;
        ins  = stimMem[0][7:0];
        zOut = stimMem[1][0];
        startRun("first start", ok);
        if (!ok) return;
        for (int k = 0; k < numLines; k++) begin
            @(posedge clk);
            #2;
            if (k + 1 < numLines) begin  // next opcode must be there by its decode
                ins  = stimMem[4*(k+1)][7:0];
                zOut = stimMem[4*(k+1)+1][0];
            end else begin
                ins  = illegalOp;
                zOut = 1'b0;
            end
            name = $sformatf("line %0d op %h", k + 1, stimMem[4*k][7:0]);
            runToDecode(32, ok);
            if (!ok) return;
            checkLine(name, k);
        end
        seen = 1'b0;
        for (int i = 0; i < 8 && !seen; i++) begin
            @(negedge clk);
            seen = ready;
        end
        if (!seen) begin
            $display("ERROR: ready did not return after the illegal opcode");
            timeoutCount++;
            return;
        end
        checkVal("illegal ctrl", 0, ctrl);
        @(posedge clk);
        #2;
        ins = opEnd;
        startRun("second start", ok);
        if (!ok) return;
        seen = 1'b0;
        for (int i = 0; i < 8 && !seen; i++) begin
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            $display("ERROR: done did not rise after the end instruction");
            timeoutCount++;
            return;
        end
        repeat (10) begin
            checkVal("halt done", 1, done);
            checkVal("halt ready", 0, ready);
            checkVal("halt ctrl", haltWord, ctrl);
            @(negedge clk);
        end
    endtask

    initial begin
        rstN         = 1'b0;
        start        = 1'b0;
        zOut         = 1'b0;
        ins          = '0;
        errCount     = 0;
        timeoutCount = 0;
        checkCount   = 0;
        $readmemh("tests/controlUnit_stim.txt", stimMem);
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;
        runTests();
        $display("checks: %0d  errors: %0d  timeouts: %0d", checkCount, errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/ctrlPkg.sv
verilog/isaPkg.sv
verilog/instrDecoder.sv
verilog/stepSequencer.sv
verilog/ctrlWordGen.sv
verilog/controlUnit.sv
tests/controlUnit_props.sv
tests/tbControlUnit.sv

/* tests/controlUnit_stim.txt */
// columns: opcode, zOut, decode-to-decode cycles, first control word after decode
// all values hex, memWait = 1
00 0 4 000000
02 0 4 100041
0B 0 4 300051
0C 0 4 400055
0A 0 4 570059
0D 0 4 600041
1F 0 4 00080C
2F 0 4 00020C
3F 0 4 00010C
4F 0 4 00040C
5F 0 4 00400C
6F 0 4 00008C
7F 0 4 20005D
8F 0 4 200061
9F 0 4 200065
04 0 6 00800C
05 0 6 00800C
03 0 8 001004
06 0 8 001004
07 0 6 001004
08 0 6 001004
08 1 4 080000
09 1 6 001004
09 0 4 080000
